//--- design/frameCam_macros.svh
`ifndef frameCamMacrosSvh
`define frameCamMacrosSvh

// pixel tick and ADC timing, in clock cycles
`define PhaseCount 10 // clocks per pixel tick
`define SamplePhase 6 // ADC word taken at this phase
`define AdcClockFirst 2 // ADC clock high from here
`define AdcClockLast 6 // up to and including this phase

// frame geometry in ticks and lines
`define LineTicks 40 // ticks per line
`define ActiveColFirst 11 // first active column
`define ActiveCols 24 // active columns per line
`define ActiveLineFirst 4 // first active line
`define ActiveLines 8 // active lines per frame
`define FrameLines 14 // lines per frame
`define FrameSyncTicks 6 // frame sync low for this many ticks

// timestamp
`define TimerDivide 8 // clocks per timestamp step
`define TimerWrap 31'd863999999 // last value before wrap to zero

// queue depths
`define HitDepth 16
`define StampDepth 8

// register map
`define AddrCtrl 6'd0
`define AddrStamp0 6'd4
`define AddrStamp1 6'd5
`define AddrStamp2 6'd6
`define AddrStamp3 6'd7
`define AddrThresh0 6'd8
`define AddrThresh1 6'd9
`define AddrFifoStamp0 6'd10
`define AddrFifoStamp1 6'd11
`define AddrFifoStamp2 6'd12
`define AddrFifoStamp3 6'd13
`define AddrHit0 6'd14
`define AddrHit1 6'd15
`define AddrHit2 6'd16
`define AddrHit3 6'd17
`define AddrHitCtrl 6'd18

`endif

//--- design/frameCamPkg.sv
package frameCamPkg;

	typedef logic [7:0] busByteT; // processor data byte
	typedef logic [5:0] regAddrT; // register address on the bus

	typedef logic [12:0] adcWordT; // raw ADC word
	typedef logic [9:0] pixelT; // ADC bits 11..2

	typedef logic [8:0] columnT; // tick within a line
	typedef logic [8:0] lineT; // line within a frame

	// line in the low half, column in the high half
	typedef logic [17:0] hitT;

	typedef logic [30:0] stampT; // timestamp value
	typedef logic [3:0] phaseT; // clock within a pixel tick

	// frame sequencer
	typedef enum logic {
		frameIdle, // waiting for go
		frameRun // one frame in progress
	} frameStateT;

endpackage

//--- design/syncFifo.sv
`timescale 1ns/1ps

module syncFifo #(
	parameter int Width = 8,
	parameter int Depth = 16
) (
	input logic bls0we,
	input logic resadd,
	input logic push,
	input logic pop,
	input logic [Width-1:0] pushData,
	output logic [Width-1:0] head, // oldest entry
	output logic empty,
	output logic full
);

	localparam int AddrWidth = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CountWidth = $clog2(Depth + 1);

	logic [Width-1:0] mem [Depth];
	logic [AddrWidth-1:0] wrPtr;
	logic [AddrWidth-1:0] rdPtr;
	logic [CountWidth-1:0] count; // entries held
	logic doPush;
	logic doPop;

	assign doPush = push && !full; // dropped when full
	assign doPop = pop && !empty; // ignored when empty

	always_ff @(posedge bls0we) begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= (wrPtr == AddrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == AddrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

	assign head = mem[rdPtr]; // valid whenever not empty
	assign empty = (count == '0);
	assign full = (count == CountWidth'(Depth));

	countBound: assert property (@(posedge bls0we) disable iff (resadd)
		count <= CountWidth'(Depth))
		else $error("FIFO count above depth");

endmodule

//--- design/busRegs.sv
`timescale 1ns/1ps
`include "frameCam_macros.svh"

module busRegs import frameCamPkg::*; (
	input logic bls0we,
	input logic resadd,
	input logic cs, // active low select
	input logic wr, // one cycle write strobe
	input logic oe, // active low read level
	input regAddrT adresBus,
	input busByteT dataIn,
	input logic frameDone, // clears go
	input stampT stampCaptured,
	input logic shotSeen,
	input stampT stampHead,
	input logic stampEmpty,
	input logic stampFull,
	input hitT hitHead,
	input logic hitEmpty,
	input logic hitFull,
	output busByteT dataOut,
	output logic dataOe,
	output logic runReq,
	output logic goPulse,
	output logic timerClear,
	output pixelT threshold,
	output logic stampPop,
	output logic hitPop
);

	logic writeEn; // bus write this cycle
	logic ctrlWrite; // write to control register
	logic go; // frame request, self clearing
	logic mapped; // address has a register behind it
	busByteT readByte; // selected read lane

	assign writeEn = wr && !cs;
	assign ctrlWrite = writeEn && (adresBus == `AddrCtrl);

	// control register with go, timer clear and the pulses
	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			go <= 1'b0;
			timerClear <= 1'b0;
			goPulse <= 1'b0;
			stampPop <= 1'b0;
			hitPop <= 1'b0;
		end else begin
			goPulse <= ctrlWrite && dataIn[0]; // any write of 1 to go
			stampPop <= ctrlWrite && dataIn[4]; // advance stamp queue
			hitPop <= writeEn && (adresBus == `AddrHitCtrl) && dataIn[4];
			if (ctrlWrite)
				timerClear <= dataIn[6]; // level that holds timer at zero
			if (ctrlWrite && dataIn[0])
				go <= 1'b1; // a new write wins over frame end
			else if (frameDone)
				go <= 1'b0;
		end
	end

	assign runReq = go;

	// two byte threshold register
	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			threshold <= '0;
		end else if (writeEn) begin
			if (adresBus == `AddrThresh0)
				threshold[7:0] <= dataIn;
			if (adresBus == `AddrThresh1)
				threshold[9:8] <= dataIn[1:0]; // upper bits of byte 9 dropped
		end
	end

	// read lanes
	always_comb begin
		readByte = '0;
		mapped = 1'b1;
		case (adresBus)
			`AddrCtrl: readByte = {4'b0000, stampEmpty, stampFull, shotSeen, go};
			`AddrStamp0: readByte = stampCaptured[7:0];
			`AddrStamp1: readByte = stampCaptured[15:8];
			`AddrStamp2: readByte = stampCaptured[23:16];
			`AddrStamp3: readByte = {1'b0, stampCaptured[30:24]};
			`AddrThresh0: readByte = threshold[7:0];
			`AddrThresh1: readByte = {6'b000000, threshold[9:8]};
			`AddrFifoStamp0: readByte = stampHead[7:0];
			`AddrFifoStamp1: readByte = stampHead[15:8];
			`AddrFifoStamp2: readByte = stampHead[23:16];
			`AddrFifoStamp3: readByte = {1'b0, stampHead[30:24]};
			`AddrHit0: readByte = hitHead[7:0]; // line low byte
			`AddrHit1: readByte = {7'b0000000, hitHead[8]}; // line msb
			`AddrHit2: readByte = hitHead[16:9]; // column low byte
			`AddrHit3: readByte = {7'b0000000, hitHead[17]}; // column msb
			`AddrHitCtrl: readByte = {4'b0000, hitEmpty, hitFull, 2'b00};
			default: mapped = 1'b0;
		endcase
	end

	assign dataOe = !cs && !oe && mapped; // drive only on a mapped read
	assign dataOut = dataOe ? readByte : '0;

	// each pop removes one entry, so a pop pulse lasts a single cycle
	popSingle: assert property (@(posedge bls0we) disable iff (resadd)
		(stampPop || hitPop) |=> !(stampPop || hitPop))
		else $error("FIFO pop pulse longer than one cycle");

endmodule

//--- design/frameTiming.sv
`timescale 1ns/1ps
`include "frameCam_macros.svh"

module frameTiming import frameCamPkg::*; (
	input logic bls0we,
	input logic resadd,
	input logic runReq, // go level from the register bank
	output logic frameDone, // last cycle of the frame
	output phaseT phase,
	output columnT column,
	output lineT line,
	output logic activePix, // inside the active window
	output logic mclock,
	output logic mfsync,
	output logic mlsync,
	output logic adcClock
);

	frameStateT state;
	logic running;
	logic tickEnd; // last clock of a tick
	logic lineEnd; // last tick of a line
	logic colActive;
	logic lineActive;

	assign running = (state == frameRun);
	assign tickEnd = (phase == phaseT'(`PhaseCount - 1));
	assign lineEnd = (column == columnT'(`LineTicks - 1));
	assign frameDone = running && tickEnd && lineEnd && (line == lineT'(`FrameLines - 1));

	// sequencer and counters, all zero while idle
	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			state <= frameIdle;
			phase <= '0;
			column <= '0;
			line <= '0;
			mclock <= 1'b1; // inactive level
		end else begin
			case (state)
				frameIdle: begin
					if (runReq) begin
						state <= frameRun;
						mclock <= ~mclock; // first tick starts
					end
				end
				frameRun: begin
					if (frameDone) begin
						state <= frameIdle; // counters back to zero
						phase <= '0;
						column <= '0;
						line <= '0;
					end else if (tickEnd) begin
						phase <= '0;
						mclock <= ~mclock; // next tick starts
						if (lineEnd) begin
							column <= '0;
							line <= line + 9'd1;
						end else begin
							column <= column + 9'd1;
						end
					end else begin
						phase <= phase + 4'd1;
					end
				end
				default: state <= frameIdle;
			endcase
		end
	end

	// sync decode, active low toward the sensor
	assign mfsync = !(running && (line == '0) && (column < columnT'(`FrameSyncTicks)));
	assign mlsync = !(running && (column == '0)); // tick 0 of each line

	// adc clock window inside each tick
	assign adcClock = running && (phase >= phaseT'(`AdcClockFirst))
		&& (phase <= phaseT'(`AdcClockLast));

	assign colActive = (column >= columnT'(`ActiveColFirst))
		&& (column < columnT'(`ActiveColFirst + `ActiveCols));
	assign lineActive = (line >= lineT'(`ActiveLineFirst))
		&& (line < lineT'(`ActiveLineFirst + `ActiveLines));
	assign activePix = running && colActive && lineActive;

	// column wraps before reaching the line length
	columnRange: assert property (@(posedge bls0we) disable iff (resadd)
		column < columnT'(`LineTicks))
		else $error("column counter out of range");

endmodule

//--- design/pixelCapture.sv
`timescale 1ns/1ps
`include "frameCam_macros.svh"

module pixelCapture import frameCamPkg::*; (
	input logic bls0we,
	input logic resadd,
	input adcWordT adcData,
	input phaseT phase,
	input columnT column,
	input lineT line,
	input logic activePix,
	input pixelT threshold,
	output logic hitPush,
	output hitT hitWord
);

	pixelT pixelReg; // sampled value
	columnT colReg; // where it was sampled
	lineT lineReg;
	logic sampleValid; // a sample waits for its compare
	logic samplePoint;
	logic pushPoint;

	assign samplePoint = activePix && (phase == phaseT'(`SamplePhase));
	assign pushPoint = (phase == phaseT'(`PhaseCount - 1)); // phase 9

	// sampled pixel with its column and line
	always_ff @(posedge bls0we) begin
		if (samplePoint) begin
			pixelReg <= adcData[11:2];
			colReg <= column;
			lineReg <= line;
		end
	end

	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd)
			sampleValid <= 1'b0;
		else if (samplePoint)
			sampleValid <= 1'b1;
		else if (pushPoint)
			sampleValid <= 1'b0; // consumed at end of tick
	end

	// push three clocks after sampling
	assign hitPush = sampleValid && pushPoint && (pixelReg >= threshold);
	assign hitWord = {colReg, lineReg}; // column high and line low

endmodule

//--- design/shotTimer.sv
`timescale 1ns/1ps
`include "frameCam_macros.svh"

module shotTimer import frameCamPkg::*; (
	input logic bls0we,
	input logic resadd,
	input logic foto, // async shot input
	input logic ready,
	input logic timerClear, // hold timer at zero
	input logic goPulse, // arms the first shot capture
	output stampT stampCaptured,
	output logic shotSeen,
	output logic stampPush,
	output stampT stampWord
);

	localparam int PreWidth = $clog2(`TimerDivide);

	logic [PreWidth-1:0] preCount; // prescaler
	stampT timestamp;
	logic fotoSync1;
	logic fotoSync2;
	logic fotoLast; // for the rising edge
	logic shotEdge;

	// timestamp prescaler and counter
	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			preCount <= '0;
			timestamp <= '0;
		end else if (timerClear) begin
			preCount <= '0;
			timestamp <= '0;
		end else if (preCount == PreWidth'(`TimerDivide - 1)) begin
			preCount <= '0;
			if (timestamp == `TimerWrap)
				timestamp <= '0;
			else
				timestamp <= timestamp + 31'd1;
		end else begin
			preCount <= preCount + 1'b1;
		end
	end

	// two flop synchronizer, then edge detect
	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			fotoSync1 <= 1'b0;
			fotoSync2 <= 1'b0;
			fotoLast <= 1'b0;
		end else begin
			fotoSync1 <= foto;
			fotoSync2 <= fotoSync1;
			fotoLast <= fotoSync2;
		end
	end

	assign shotEdge = fotoSync2 && !fotoLast && ready; // only with ready high

	// every shot queues its stamp on this edge
	assign stampPush = shotEdge;
	assign stampWord = timestamp;

	// first shot after go is kept for the bus
	always_ff @(posedge bls0we or posedge resadd) begin
		if (resadd) begin
			shotSeen <= 1'b0;
			stampCaptured <= '0;
		end else if (goPulse) begin
			shotSeen <= 1'b0; // rearm
		end else if (shotEdge && !shotSeen) begin
			shotSeen <= 1'b1;
			stampCaptured <= timestamp;
		end
	end

endmodule

//--- design/frameCam.sv
`timescale 1ns/1ps
`include "frameCam_macros.svh"

module frameCam import frameCamPkg::*; (
	input logic bls0we,
	input logic resadd,
	input logic cs,
	input logic wr,
	input logic oe,
	input regAddrT adresBus,
	input busByteT dataIn,
	input adcWordT adcData,
	input logic foto,
	input logic ready,
	output busByteT dataOut,
	output logic dataOe,
	output logic mclock,
	output logic mfsync,
	output logic mlsync,
	output logic adcClock
);

	logic runReq, frameDone, goPulse, timerClear; // control between blocks
	pixelT threshold;
	phaseT phase;
	columnT column;
	lineT line;
	logic activePix;
	logic hitPush, hitPop, hitEmpty, hitFull; // hit queue
	hitT hitWord, hitHead;
	logic stampPush, stampPop, stampEmpty, stampFull; // stamp queue
	stampT stampWord, stampHead, stampCaptured;
	logic shotSeen;

	busRegs busRegsInst (.bls0we, .resadd, .cs, .wr, .oe, .adresBus, .dataIn, .frameDone,
		.stampCaptured, .shotSeen, .stampHead, .stampEmpty, .stampFull, .hitHead,
		.hitEmpty, .hitFull, .dataOut, .dataOe, .runReq, .goPulse, .timerClear,
		.threshold, .stampPop, .hitPop);

	frameTiming timingInst (.bls0we, .resadd, .runReq, .frameDone, .phase, .column,
		.line, .activePix, .mclock, .mfsync, .mlsync, .adcClock);

	pixelCapture captureInst (.bls0we, .resadd, .adcData, .phase, .column, .line,
		.activePix, .threshold, .hitPush, .hitWord);

	shotTimer timerInst (.bls0we, .resadd, .foto, .ready, .timerClear, .goPulse,
		.stampCaptured, .shotSeen, .stampPush, .stampWord);

	syncFifo #(.Width($bits(hitT)), .Depth(`HitDepth)) hitFifo (.bls0we, .resadd,
		.push(hitPush), .pop(hitPop), .pushData(hitWord), .head(hitHead),
		.empty(hitEmpty), .full(hitFull));

	syncFifo #(.Width($bits(stampT)), .Depth(`StampDepth)) stampFifo (.bls0we, .resadd,
		.push(stampPush), .pop(stampPop), .pushData(stampWord), .head(stampHead),
		.empty(stampEmpty), .full(stampFull));

endmodule

//--- bench/frameCamTb.sv
`timescale 1ns/1ps
`include "frameCam_macros.svh"

module frameCamTb import frameCamPkg::*; ();

	localparam int FrameCycles = `FrameLines * `LineTicks * `PhaseCount; // clocks per frame
	localparam int HitSlots = `ActiveCols * `ActiveLines; // active pixels per frame

	logic bls0we, resadd, cs, wr, oe, foto, ready;
	regAddrT adresBus;
	busByteT dataIn;
	adcWordT adcData;
	busByteT dataOut;
	logic dataOe, mclock, mfsync, mlsync, adcClock;
	logic [31:0] lfsrState = 32'hbf70;
	int valueErrors; // wrong values seen
	int timeouts; // waits that gave up

	frameCam frameCam_inst (.*);

	always #20 bls0we = ~bls0we; // 40 ns period

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	task automatic checkByte(input busByteT got, input busByteT expected, input string what);
		if (got !== expected) begin
			valueErrors++;
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic checkStamp(input stampT got, input stampT expected, input int slack,
		input string what);
		longint distance;
		distance = (got > expected) ? longint'(got - expected) : longint'(expected - got);
		if ($isunknown(got) || distance > slack) begin
			valueErrors++;
			$display("ERROR at %0t ns: %s is %0d, expected %0d within %0d", $time, what, got,
				expected, slack);
		end
	endtask

	task automatic checkHit(input hitT got, input hitT expected, input string what);
		if (got !== expected) begin
			valueErrors++;
			$display("ERROR at %0t ns: %s is column %0d line %0d, expected column %0d line %0d",
				$time, what, got[17:9], got[8:0], expected[17:9], expected[8:0]);
		end
	endtask

	task automatic checkBit(input logic got, input logic expected, input string what);
		if (got !== expected) begin
			valueErrors++;
			$display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, expected);
		end
	endtask

	task automatic noteTimeout(input string what);
		timeouts++;
		$display("Timed out waiting for %s", what);
	endtask

	// register takes dataIn on the rising edge in between
	task automatic busWrite(input regAddrT addr, input busByteT data);
		@(negedge bls0we);
		adresBus = addr;
		dataIn = data;
		cs = 1'b0;
		wr = 1'b1;
		@(negedge bls0we);
		cs = 1'b1;
		wr = 1'b0;
	endtask

	task automatic busRead(input regAddrT addr, output busByteT data);
		@(negedge bls0we);
		adresBus = addr;
		cs = 1'b0;
		oe = 1'b0;
		#10; // mid low phase, read path settled
		data = dataOut;
		checkBit(dataOe, 1'b1, "dataOe during read");
		@(negedge bls0we);
		cs = 1'b1;
		oe = 1'b1;
	endtask

	task automatic readStamp(input regAddrT base, output stampT value);
		busByteT b0, b1, b2, b3;
		busRead(base, b0);
		busRead(base + 6'd1, b1);
		busRead(base + 6'd2, b2);
		busRead(base + 6'd3, b3);
		value = {b3[6:0], b2, b1, b0};
	endtask

	task automatic readHitHead(output hitT value);
		busByteT b0, b1, b2, b3;
		busRead(`AddrHit0, b0); // line low byte
		busRead(`AddrHit1, b1);
		busRead(`AddrHit2, b2); // column low byte
		busRead(`AddrHit3, b3);
		value = {b3[0], b2, b1[0], b0};
	endtask

	// poll one status bit until it reaches the level
	task automatic waitStatus(input regAddrT addr, input int bitIdx, input logic level,
		input string what);
		busByteT data;
		int tries;
		tries = 0;
		busRead(addr, data);
		while (data[bitIdx] !== level && tries < 64) begin
			busRead(addr, data);
			tries++;
		end
		if (data[bitIdx] !== level)
			noteTimeout(what);
	endtask

	task automatic writeThreshold(input pixelT value);
		busWrite(`AddrThresh0, value[7:0]);
		busWrite(`AddrThresh1, {6'b101101, value[9:8]}); // junk in the unused bits
	endtask

	// one frame per go write, the window length is fixed by the frame timing
	task automatic runFrame(output int pulses);
		logic lastSync;
		pulses = 0;
		lastSync = 1'b1;
		busWrite(`AddrCtrl, 8'h01);
		repeat (FrameCycles + 16) begin
			@(negedge bls0we);
			if (lastSync && !mlsync) begin
				if (pulses == 0)
					checkBit(mfsync, 1'b0, "mfsync at frame start");
				pulses++;
			end
			lastSync = mlsync;
		end
		waitStatus(`AddrCtrl, 0, 1'b0, "go to clear after the frame");
	endtask

	task automatic popHits(output int pops, output hitT first);
		busByteT status;
		hitT head;
		pops = 0;
		first = '0;
		busRead(`AddrHitCtrl, status);
		while (!status[3] && pops < 64) begin
			readHitHead(head);
			if (pops == 0)
				first = head; // oldest entry
			busWrite(`AddrHitCtrl, 8'h10);
			pops++;
			busRead(`AddrHitCtrl, status);
		end
		if (!status[3])
			noteTimeout("hit FIFO to drain");
	endtask

	task automatic resetState;
		busByteT data;
		@(negedge bls0we);
		checkBit(dataOe, 1'b0, "dataOe while idle");
		checkBit(mfsync, 1'b1, "mfsync after reset");
		checkBit(mlsync, 1'b1, "mlsync after reset");
		checkBit(mclock, 1'b1, "mclock after reset");
		checkBit(adcClock, 1'b0, "adcClock after reset");
		busRead(`AddrCtrl, data);
		checkByte(data, 8'h08, "control status after reset"); // only stampEmpty
		busRead(`AddrHitCtrl, data);
		checkByte(data, 8'h08, "hit status after reset");
		busRead(`AddrThresh0, data);
		checkByte(data, 8'h00, "threshold after reset");
	endtask

	task automatic thresholdReg;
		pixelT value;
		busByteT data;
		value = pixelT'(randomBits(10));
		writeThreshold(value);
		busRead(`AddrThresh0, data);
		checkByte(data, value[7:0], "threshold byte 8");
		busRead(`AddrThresh1, data);
		checkByte(data, {6'b000000, value[9:8]}, "threshold byte 9");
	endtask

	task automatic frameRun;
		int pulses;
		runFrame(pulses);
		checkByte(busByteT'(pulses), busByteT'(`FrameLines), "line sync pulses per frame");
	endtask

	task automatic pixelHits;
		pixelT level;
		logic [31:0] noise;
		busByteT data;
		hitT first;
		int pops;
		int pulses;
		popHits(pops, first); // leftovers from earlier frames
		level = pixelT'(randomBits(9)); // leaves room for level + 1
		noise = randomBits(3);
		adcData = {noise[2], level, noise[1:0]};
		writeThreshold(level);
		runFrame(pulses);
		busRead(`AddrHitCtrl, data);
		checkByte(data, 8'h04, "hit status after a full frame");
		popHits(pops, first);
		checkHit(first, {columnT'(`ActiveColFirst), lineT'(`ActiveLineFirst)}, "first hit");
		checkByte(busByteT'(pops), busByteT'((HitSlots < `HitDepth) ? HitSlots : `HitDepth),
			"hits popped");
		writeThreshold(level + 10'd1); // one above every pixel
		runFrame(pulses);
		busRead(`AddrHitCtrl, data);
		checkByte(data, 8'h08, "hit status with threshold above pixels");
	endtask

	task automatic shotStamp;
		int delay;
		stampT captured, head, again;
		ready = 1'b1;
		busWrite(`AddrCtrl, 8'h40); // hold timer at zero
		busWrite(`AddrCtrl, 8'h00); // release
		delay = 20 + int'(randomBits(8));
		repeat (delay) @(negedge bls0we);
		foto = 1'b1;
		waitStatus(`AddrCtrl, 1, 1'b1, "first shot to register");
		readStamp(`AddrStamp0, captured);
		// registered 3 clocks after foto rises
		checkStamp(captured, stampT'((delay + 3) / `TimerDivide), 1, "captured stamp");
		readStamp(`AddrFifoStamp0, head);
		checkStamp(head, captured, 0, "stamp FIFO head");
		busWrite(`AddrCtrl, 8'h10); // pop first stamp
		foto = 1'b0;
		repeat (8 + int'(randomBits(6))) @(negedge bls0we);
		foto = 1'b1;
		waitStatus(`AddrCtrl, 3, 1'b0, "second stamp in the FIFO");
		readStamp(`AddrFifoStamp0, head);
		checkBit(head > captured, 1'b1, "second stamp larger than first");
		readStamp(`AddrStamp0, again);
		checkStamp(again, captured, 0, "captured stamp after second shot");
		foto = 1'b0;
	endtask

	task automatic shotGating;
		busByteT data;
		busWrite(`AddrCtrl, 8'h10); // pop second stamp
		waitStatus(`AddrCtrl, 3, 1'b1, "stamp FIFO to empty");
		ready = 1'b0;
		foto = 1'b1;
		repeat (6) @(negedge bls0we);
		foto = 1'b0;
		repeat (6) @(negedge bls0we);
		busRead(`AddrCtrl, data);
		checkBit(data[3], 1'b1, "stamp FIFO empty after shot without ready");
	endtask

	initial begin
		bls0we = 1'b0;
		resadd = 1'b1;
		cs = 1'b1;
		wr = 1'b0;
		oe = 1'b1;
		adresBus = '0;
		dataIn = '0;
		adcData = '0;
		foto = 1'b0;
		ready = 1'b0;
		valueErrors = 0;
		timeouts = 0;
		repeat (8) @(posedge bls0we);
		@(negedge bls0we);
		resadd = 1'b0;
		resetState;
		thresholdReg;
		frameRun;
		pixelHits;
		shotStamp;
		shotGating;
		$display("value errors: %0d, timeouts: %0d", valueErrors, timeouts);
		if (valueErrors == 0 && timeouts == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- project.f
+incdir+design
design/frameCamPkg.sv
design/syncFifo.sv
design/busRegs.sv
design/frameTiming.sv
design/pixelCapture.sv
design/shotTimer.sv
design/frameCam.sv
bench/frameCamTb.sv
